// File: build.f
src/rv_core_pkg.sv
src/pc_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/rv_core_top.sv
testbench/rv_core_assertions.sv
testbench/tb_rv_core.sv

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import rv_core_pkg::*;
(
  input  word_t      inst,
  output reg_addr_t  rs1_addr,
  output reg_addr_t  rs2_addr,
  output reg_addr_t  rd,
  output logic [2:0] funct3,
  output word_t      imm,
  output op_class_t  op_class,
  output alu_op_t    alu_op,
  output logic       use_imm
);

  logic [6:0] opcode;
  logic       alt;
  logic       is_shift;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode   = inst[6:0];
  assign rd       = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign alt      = inst[F7_ALT];

  // sign-extended immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SR);

  // instruction class
  always_comb begin
    case (opcode)
      OPC_OP:     op_class = CLS_OP;
      OPC_OP_IMM: op_class = CLS_OP_IMM;
      OPC_LUI:    op_class = CLS_LUI;
      OPC_AUIPC:  op_class = CLS_AUIPC;
      OPC_JAL:    op_class = CLS_JAL;
      OPC_JALR:   op_class = (funct3 == 3'b000) ? CLS_JALR : CLS_ILLEGAL;
      OPC_BRANCH: op_class = CLS_BRANCH;
      OPC_SYSTEM: begin
        // only ebreak, imm = 1 and every other field zero
        if (inst[31:7] == {12'h001, 13'h0000}) begin
          op_class = CLS_EBREAK;
        end else begin
          op_class = CLS_ILLEGAL;
        end
      end
      default:    op_class = CLS_ILLEGAL;
    endcase
  end

  always_comb begin
    case (op_class)
      CLS_OP_IMM: imm = is_shift ? {27'b0, inst[24:20]} : imm_i; // shamt for shifts
      CLS_JALR:   imm = imm_i;
      CLS_LUI,
      CLS_AUIPC:  imm = imm_u;
      CLS_JAL:    imm = imm_j;
      CLS_BRANCH: imm = imm_b;
      default:    imm = '0;
    endcase
  end

  always_comb begin
    case (funct3)
      F3_ADD:  alu_op = (op_class == CLS_OP && alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:  alu_op = ALU_SLL;
      F3_SLT:  alu_op = ALU_SLT;
      F3_SLTU: alu_op = ALU_SLTU;
      F3_XOR:  alu_op = ALU_XOR;
      F3_SR:   alu_op = alt ? ALU_SRA : ALU_SRL; // srai also uses bit 30
      F3_OR:   alu_op = ALU_OR;
      F3_AND:  alu_op = ALU_AND;
      default: alu_op = ALU_ADD;
    endcase
  end

  assign use_imm = (op_class == CLS_OP_IMM);

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  import rv_core_pkg::*;
(
  input  op_class_t op_class,
  input  alu_op_t   alu_op,
  input  logic      use_imm,
  input  reg_addr_t rd,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  word_t     imm,
  input  word_t     link,
  input  word_t     pc_rel,
  output logic      rd_we,
  output reg_addr_t rd_addr,
  output word_t     rd_wdata
);

  word_t      opnd_b;
  word_t      alu_res;
  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       wb_class;

  assign opnd_b = use_imm ? imm : rs2_data;
  assign shamt  = opnd_b[4:0]; // upper bits ignored

  assign lt_s = ($signed(rs1_data) < $signed(opnd_b));
  assign lt_u = (rs1_data < opnd_b);

  // alu
  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_res = rs1_data + opnd_b;
      ALU_SUB:  alu_res = rs1_data - opnd_b;
      ALU_SLL:  alu_res = rs1_data << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  alu_res = rs1_data ^ opnd_b;
      ALU_SRL:  alu_res = rs1_data >> shamt;
      ALU_SRA:  alu_res = $signed(rs1_data) >>> shamt;
      ALU_OR:   alu_res = rs1_data | opnd_b;
      ALU_AND:  alu_res = rs1_data & opnd_b;
      default:  alu_res = '0;
    endcase
  end

  // write-back select
  always_comb begin
    wb_class = 1'b1;
    case (op_class)
      CLS_OP,
      CLS_OP_IMM: rd_wdata = alu_res;
      CLS_LUI:    rd_wdata = imm;
      CLS_AUIPC:  rd_wdata = pc_rel;
      CLS_JAL,
      CLS_JALR:   rd_wdata = link; // return address
      default: begin
        rd_wdata = '0;
        wb_class = 1'b0; // branch, ebreak, illegal
      end
    endcase
  end

  assign rd_we   = wb_class && (rd != '0); // x0 writes dropped here
  assign rd_addr = rd;

endmodule

// File: src/pc_stage.sv
`timescale 1ns/1ps

module pc_stage
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  op_class_t op_class,
  input  logic [2:0] funct3,
  input  word_t     imm,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output word_t     pc,
  output word_t     link,
  output word_t     pc_rel,
  output logic      halt
);

  word_t next_pc;
  word_t jalr_target;
  logic  taken;

  assign link        = pc + 32'd4;    // static next pc
  assign pc_rel      = pc + imm;      // branch, jal, auipc
  assign jalr_target = rs1_data + imm; // bit 0 kept as is

  assign halt = (op_class == CLS_EBREAK);

  // branch comparator
  always_comb begin
    case (funct3)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: taken = (rs1_data < rs2_data);
      F3_BGEU: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0; // 010 / 011 are not branches
    endcase
  end

  always_comb begin
    case (op_class)
      CLS_BRANCH: next_pc = taken ? pc_rel : link;
      CLS_JAL:    next_pc = pc_rel;
      CLS_JALR:   next_pc = jalr_target;
      CLS_EBREAK: next_pc = pc;         // freeze on halt
      default:    next_pc = link;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2
);

  word_t regs [1:31]; // no storage for x0

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // no write bypass
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: src/rv_core_pkg.sv
package rv_core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  localparam word_t RESET_PC = 32'h8000_0000;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // alu function codes, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam int F7_ALT = 30; // sub / sra select bit

  typedef enum logic [3:0] {
    CLS_OP,
    CLS_OP_IMM,
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_JALR,
    CLS_BRANCH,
    CLS_EBREAK,
    CLS_ILLEGAL
  } op_class_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

endpackage

// File: src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  output word_t     imem_addr,
  input  word_t     imem_data,
  output logic      rd_we,
  output reg_addr_t rd_addr,
  output word_t     rd_wdata,
  output logic      halt
);

  word_t      pc;
  word_t      link;
  word_t      pc_rel;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  reg_addr_t  rd;
  logic [2:0] funct3;
  word_t      imm;
  op_class_t  op_class;
  alu_op_t    alu_op;
  logic       use_imm;
  word_t      rs1_data;
  word_t      rs2_data;

  assign imem_addr = pc;

  pc_stage u_pc (
    .clk      (clk),
    .arst_n   (arst_n),
    .op_class (op_class),
    .funct3   (funct3),
    .imm      (imm),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .link     (link),
    .pc_rel   (pc_rel),
    .halt     (halt)
  );

  decode_stage u_dec (
    .inst     (imem_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd       (rd),
    .funct3   (funct3),
    .imm      (imm),
    .op_class (op_class),
    .alu_op   (alu_op),
    .use_imm  (use_imm)
  );

  reg_file u_rf (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (rd_we),
    .waddr  (rd_addr),
    .wdata  (rd_wdata),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  execute_stage u_ex (
    .op_class (op_class),
    .alu_op   (alu_op),
    .use_imm  (use_imm),
    .rd       (rd),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .link     (link),
    .pc_rel   (pc_rel),
    .rd_we    (rd_we),
    .rd_addr  (rd_addr),
    .rd_wdata (rd_wdata)
  );

endmodule

// File: testbench/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions
  import rv_core_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input word_t     pc,
  input logic      halt,
  input logic      rd_we,
  input reg_addr_t rd_addr
);

  int errors = 0; // failure count, read back from the testbench

  pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    !halt |-> pc[1:0] == 2'b00) else begin
    $error("pc %h is not word aligned", pc);
    errors++;
  end

  // x0 is never a write target
  no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
    rd_we |-> rd_addr != '0) else begin
    $error("register write enabled with rd_addr zero");
    errors++;
  end

  pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
    halt |=> pc == $past(pc)) else begin
    $error("pc moved while halt was high");
    errors++;
  end

endmodule

bind rv_core_top rv_core_assertions u_checks (
  .clk     (clk),
  .arst_n  (arst_n),
  .pc      (pc),
  .halt    (halt),
  .rd_we   (rd_we),
  .rd_addr (rd_addr)
);

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import rv_core_pkg::*;
();

  typedef struct packed {
    word_t     inst;
    word_t     addr;  // expected imem_addr
    logic      we;
    reg_addr_t rd;
    word_t     wdata; // only checked when we is set
  } step_t;

  logic      clk = 1'b0;
  logic      arst_n;
  word_t     imem_data;
  word_t     imem_addr;
  logic      rd_we;
  reg_addr_t rd_addr;
  word_t     rd_wdata;
  logic      halt;
  step_t     prog [$];

  rv_core_top uut (.*);

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
      abort_run($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp)
      abort_run($sformatf("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act));
  endtask

  initial begin
    arst_n    = 1'b0;
    imem_data = '0;
    // inst, imem_addr, rd_we, rd, rd write data
    prog.push_back({32'h123450B7, 32'h80000000, 1'b1, 5'd1, 32'h12345000}); // lui x1
    prog.push_back({32'hFFB00113, 32'h80000004, 1'b1, 5'd2, 32'hFFFFFFFB}); // addi x2, -5
    prog.push_back({32'h00700193, 32'h80000008, 1'b1, 5'd3, 32'h00000007}); // addi x3, 7
    prog.push_back({32'h00118013, 32'h8000000C, 1'b0, 5'd0, 32'h00000000}); // addi x0, x3, 1
    prog.push_back({32'h00310233, 32'h80000010, 1'b1, 5'd4, 32'h00000002}); // add
    prog.push_back({32'h402002B3, 32'h80000014, 1'b1, 5'd5, 32'h00000005}); // sub x0 - x2
    prog.push_back({32'h00314333, 32'h80000018, 1'b1, 5'd6, 32'hFFFFFFFC}); // xor
    prog.push_back({32'h0030E3B3, 32'h8000001C, 1'b1, 5'd7, 32'h12345007}); // or
    prog.push_back({32'h00317433, 32'h80000020, 1'b1, 5'd8, 32'h00000003}); // and
    prog.push_back({32'h003194B3, 32'h80000024, 1'b1, 5'd9, 32'h00000380}); // sll
    prog.push_back({32'h00315533, 32'h80000028, 1'b1, 5'd10, 32'h01FFFFFF}); // srl
    prog.push_back({32'h403155B3, 32'h8000002C, 1'b1, 5'd11, 32'hFFFFFFFF}); // sra
    prog.push_back({32'h00312633, 32'h80000030, 1'b1, 5'd12, 32'h00000001}); // slt
    prog.push_back({32'h003136B3, 32'h80000034, 1'b1, 5'd13, 32'h00000000}); // sltu
    prog.push_back({32'h00001797, 32'h80000038, 1'b1, 5'd15, 32'h80001038}); // auipc
    prog.push_back({32'h00318463, 32'h8000003C, 1'b0, 5'd0, 32'h0}); // beq taken
    prog.push_back({32'h00310463, 32'h80000044, 1'b0, 5'd0, 32'h0}); // beq not taken
    prog.push_back({32'h00311463, 32'h80000048, 1'b0, 5'd0, 32'h0}); // bne taken
    prog.push_back({32'h00319463, 32'h80000050, 1'b0, 5'd0, 32'h0}); // bne not taken
    prog.push_back({32'h00314463, 32'h80000054, 1'b0, 5'd0, 32'h0}); // blt taken
    prog.push_back({32'h0021C463, 32'h8000005C, 1'b0, 5'd0, 32'h0}); // blt not taken
    prog.push_back({32'h0021D463, 32'h80000060, 1'b0, 5'd0, 32'h0}); // bge taken
    prog.push_back({32'h00315463, 32'h80000068, 1'b0, 5'd0, 32'h0}); // bge not taken
    prog.push_back({32'h0021E463, 32'h8000006C, 1'b0, 5'd0, 32'h0}); // bltu taken
    prog.push_back({32'h00316463, 32'h80000074, 1'b0, 5'd0, 32'h0}); // bltu not taken
    prog.push_back({32'h00317463, 32'h80000078, 1'b0, 5'd0, 32'h0}); // bgeu taken
    prog.push_back({32'h0021F463, 32'h80000080, 1'b0, 5'd0, 32'h0}); // bgeu not taken
    prog.push_back({32'h0100086F, 32'h80000084, 1'b1, 5'd16, 32'h80000088}); // jal +16
    prog.push_back({32'hFFC788E7, 32'h80000094, 1'b1, 5'd17, 32'h80000098}); // jalr -4(x15)

    // reset spans three rising edges
    repeat (2) @(negedge clk);
    #1;
    check_word("imem_addr", RESET_PC, imem_addr);
    check_bit("rd_we", 1'b0, rd_we);
    check_bit("halt", 1'b0, halt);
    @(negedge clk);
    arst_n = 1'b1;

    foreach (prog[i]) begin
      imem_data = prog[i].inst;
      #2; // settle before the rising edge
      check_word("imem_addr", prog[i].addr, imem_addr);
      check_bit("rd_we", prog[i].we, rd_we);
      check_bit("halt", 1'b0, halt);
      if (prog[i].we) begin
        check_reg("rd_addr", prog[i].rd, rd_addr);
        check_word("rd_wdata", prog[i].wdata, rd_wdata);
      end
      @(negedge clk);
    end

    imem_data = 32'h00100073; // ebreak
    for (int n = 0; n < 4 && !halt; n++) begin
      #1;
    end
    if (!halt) begin
      abort_run("halt did not rise after EBREAK was fetched");
    end
    check_word("imem_addr", 32'h80001034, imem_addr);
    check_bit("rd_we", 1'b0, rd_we);
    repeat (2) @(negedge clk);
    #1;
    check_word("imem_addr", 32'h80001034, imem_addr); // pc frozen
    check_bit("halt", 1'b1, halt);

    if (uut.u_checks.errors != 0) begin
      abort_run("bound assertions reported failures");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule
